//--- Makefile
# Verilator build and run of the thread coprocessor testbench
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_pu_cop, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_pu_cop -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_pu_cop)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

//--- hw/cop_pc_gen.sv
// Fetch PC is a word address and a thread load always wins over stall and branch
`timescale 1ns/1ps
`default_nettype none

module cop_pc_gen (
	input  wire logic                                clk,
	input  wire logic                                rst_,
	input  cop_pkg::thread_cmd_t                     cmd,
	input  wire logic                                branch_en,
	input  wire logic [cop_pkg::WORD_ADDR_W-1:0]     branch_pc,
	input  wire logic                                pc_stall,
	output logic [cop_pkg::WORD_ADDR_W-1:0]          cop_np_pc,
	output logic [cop_pkg::WORD_ADDR_W-1:0]          cop_pr_pc
);

	always_comb begin
		if (cmd.pc_load_en) begin
			cop_np_pc = cmd.pc_load_val;
		end else if (!cmd.run_en) begin
			// No runnable thread parks fetch at zero
			cop_np_pc = '0;
		end else if (pc_stall) begin
			cop_np_pc = cop_pr_pc;
		end else if (branch_en) begin
			cop_np_pc = branch_pc;
		end else begin
			cop_np_pc = cop_pr_pc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_) begin
		if (!rst_) begin
			cop_pr_pc <= '0;
		end else begin
			cop_pr_pc <= cop_np_pc;
		end
	end

endmodule

`default_nettype wire

//--- hw/cop_pipe_ctrl.sv
// A stage never stalls on its own busy bit and only id_hazard flushes outside a thread switch
`timescale 1ns/1ps
`default_nettype none

module cop_pipe_ctrl (
	input  cop_pkg::stage_bits_t busy,
	input  wire logic            id_hazard,
	input  wire logic            all_flush,
	output cop_pkg::stage_bits_t stall,
	output cop_pkg::stage_bits_t flush,
	output logic                 pc_stall
);

	always_comb begin
		if (all_flush) begin
			// Switch discards everything in flight
			flush    = '1;
			stall    = '0;
			pc_stall = 1'b0;
		end else begin
			flush    = '0;
			flush.id = id_hazard;

			stall.ia = busy.id | busy.ex | busy.da | busy.wb | id_hazard;
			stall.id = busy.ia | busy.ex | busy.da | busy.wb;
			stall.ex = busy.ia | busy.id | busy.da | busy.wb;
			stall.da = busy.ia | busy.id | busy.ex | busy.wb;
			stall.wb = busy.ia | busy.id | busy.ex | busy.da;

			pc_stall = (|busy) | id_hazard;
		end
	end

endmodule

`default_nettype wire

//--- hw/cop_pkg.sv
// Four thread contexts with fixed widths and reserved CPR bits always read back as zero
`default_nettype none

package cop_pkg;

	// Datapath widths and context count
	localparam int WORD_W      = 32;
	localparam int WORD_ADDR_W = 30;
	localparam int PID_NUM     = 4;
	localparam int PID_W       = 2;
	localparam int TID_W       = 8;
	localparam int CPR_ADDR_W  = 5;

	// CPR addresses share the GPR address field
	localparam logic [CPR_ADDR_W-1:0] CPR_ADDR_PID    = 5'd1;
	localparam logic [CPR_ADDR_W-1:0] CPR_ADDR_CTRL   = 5'd2;
	localparam logic [CPR_ADDR_W-1:0] CPR_ADDR_STATUS = 5'd3;
	localparam logic [CPR_ADDR_W-1:0] CPR_ADDR_TID    = 5'd4;
	localparam logic [CPR_ADDR_W-1:0] CPR_ADDR_NPC    = 5'd5;

	// Unlisted codes behave as NOP
	typedef enum logic [3:0] {
		NOP    = 4'd0,
		MT     = 4'd1,
		MKTH   = 4'd2,
		DELTH  = 4'd3,
		SWTH   = 4'd4,
		NEXTTH = 4'd5,
		SWITCH = 4'd6
	} cop_op_e;

	// ku set means kernel mode
	typedef struct packed {
		logic [WORD_W-5:0] rsvd;
		logic              ku;
		logic              ne;
		logic              act;
		logic              en;
	} cpr_status_t;

	typedef struct packed {
		logic [WORD_W-6:0] rsvd;
		logic              l2c_on;
		logic              dc_on;
		logic              dtlb_on;
		logic              ic_on;
		logic              itlb_on;
	} cpr_ctrl_t;

	// Write-back word seen as status or control depending on the CPR address
	typedef union packed {
		logic [WORD_W-1:0] raw;
		cpr_status_t       status;
		cpr_ctrl_t         ctrl;
	} cpr_word_u;

	typedef struct packed {
		logic                   en;
		logic                   act;
		logic                   ne;
		logic                   ku;
		logic [TID_W-1:0]       tid;
		logic [WORD_ADDR_W-1:0] npc;
	} thread_state_t;

	// Slot contents after reset
	localparam thread_state_t THREAD_BOOT = '{en: 1'b1, act: 1'b1, ne: 1'b1, ku: 1'b1,
		tid: '0, npc: '0};
	localparam thread_state_t THREAD_IDLE = '{en: 1'b0, act: 1'b0, ne: 1'b0, ku: 1'b1,
		tid: '0, npc: '0};

	typedef struct packed {
		logic [WORD_ADDR_W-1:0] pc;
		cop_op_e                op;
		logic [WORD_W-1:0]      cop_data;
		logic [CPR_ADDR_W-1:0]  rd_addr;
		logic                   rd_en;
		cpr_word_u              rd_data;
		logic                   bd;
	} wb_cop_t;

	typedef struct packed {
		logic ia;
		logic id;
		logic ex;
		logic da;
		logic wb;
	} stage_bits_t;

	// Decision of the scheduler for the current write-back
	typedef struct packed {
		logic                   switch_en;
		logic [PID_W-1:0]       new_pid;
		logic                   save_en;
		logic [PID_W-1:0]       save_pid;
		logic [WORD_ADDR_W-1:0] save_npc;
		logic                   make_en;
		logic [PID_W-1:0]       make_pid;
		logic [TID_W-1:0]       make_tid;
		logic                   del_en;
		logic [PID_W-1:0]       del_pid;
		logic                   pc_load_en;
		logic [WORD_ADDR_W-1:0] pc_load_val;
		logic                   run_en;
		logic                   next_en;
		logic                   all_flush;
		logic                   result_en;
		logic                   result;
	} thread_cmd_t;

endpackage

`default_nettype wire

//--- hw/cop_thread_regs.sv
// STATUS TID and NPC accesses always target the current pid and unknown CPR addresses read zero
`timescale 1ns/1ps
`default_nettype none

module cop_thread_regs (
	input  wire logic                                      clk,
	input  wire logic                                      rst_,
	input  cop_pkg::thread_cmd_t                           cmd,
	input  cop_pkg::wb_cop_t                               wb,
	input  wire logic [cop_pkg::CPR_ADDR_W-1:0]            cpr_rd_addr,
	output cop_pkg::thread_state_t [cop_pkg::PID_NUM-1:0]  threads,
	output logic [cop_pkg::PID_W-1:0]                      cur_pid,
	output cop_pkg::cpr_ctrl_t                             ctrl,
	output logic [cop_pkg::WORD_W-1:0]                     cpr_rd_data
);

	cop_pkg::thread_state_t cur_thread;
	cop_pkg::cpr_word_u     rd_word;

	assign cur_thread = threads[cur_pid];

	always_ff @(posedge clk or negedge rst_) begin
		if (!rst_) begin
			cur_pid    <= '0;
			ctrl       <= '0;
			threads[0] <= cop_pkg::THREAD_BOOT;
			for (int i = 1; i < cop_pkg::PID_NUM; i++) begin
				threads[i] <= cop_pkg::THREAD_IDLE;
			end
		end else begin
			// Register writes through MT
			if (wb.op == cop_pkg::MT) begin
				case (wb.rd_addr)
				cop_pkg::CPR_ADDR_PID: begin
					cur_pid <= wb.rd_data.raw[cop_pkg::PID_W-1:0];
				end
				cop_pkg::CPR_ADDR_CTRL: begin
					ctrl.itlb_on <= wb.rd_data.ctrl.itlb_on;
					ctrl.ic_on   <= wb.rd_data.ctrl.ic_on;
					ctrl.dtlb_on <= wb.rd_data.ctrl.dtlb_on;
					ctrl.dc_on   <= wb.rd_data.ctrl.dc_on;
					ctrl.l2c_on  <= wb.rd_data.ctrl.l2c_on;
				end
				cop_pkg::CPR_ADDR_STATUS: begin
					threads[cur_pid].en  <= wb.rd_data.status.en;
					threads[cur_pid].act <= wb.rd_data.status.act;
					threads[cur_pid].ne  <= wb.rd_data.status.ne;
					threads[cur_pid].ku  <= wb.rd_data.status.ku;
				end
				cop_pkg::CPR_ADDR_TID: begin
					threads[cur_pid].tid <= wb.rd_data.raw[cop_pkg::TID_W-1:0];
				end
				cop_pkg::CPR_ADDR_NPC: begin
					threads[cur_pid].npc <= wb.rd_data.raw[cop_pkg::WORD_ADDR_W-1:0];
				end
				default: begin
				end
				endcase
			end

			// New thread starts at the address carried in cop_data
			if (cmd.make_en) begin
				threads[cmd.make_pid].en  <= 1'b1;
				threads[cmd.make_pid].act <= 1'b1;
				threads[cmd.make_pid].ne  <= 1'b1;
				threads[cmd.make_pid].tid <= cmd.make_tid;
				threads[cmd.make_pid].npc <= wb.cop_data[cop_pkg::WORD_ADDR_W-1:0];
			end

			if (cmd.del_en) begin
				threads[cmd.del_pid] <= cop_pkg::THREAD_IDLE;
			end

			// Resume point of the thread being left
			if (cmd.save_en) begin
				threads[cmd.save_pid].npc <= cmd.save_npc;
			end

			if (cmd.switch_en) begin
				cur_pid <= cmd.new_pid;
			end
		end
	end

	// CPR read mux, fields zero-extended
	always_comb begin
		rd_word = '0;
		case (cpr_rd_addr)
		cop_pkg::CPR_ADDR_PID: begin
			rd_word.raw[cop_pkg::PID_W-1:0] = cur_pid;
		end
		cop_pkg::CPR_ADDR_CTRL: begin
			rd_word.ctrl = ctrl;
		end
		cop_pkg::CPR_ADDR_STATUS: begin
			rd_word.status.en  = cur_thread.en;
			rd_word.status.act = cur_thread.act;
			rd_word.status.ne  = cur_thread.ne;
			rd_word.status.ku  = cur_thread.ku;
		end
		cop_pkg::CPR_ADDR_TID: begin
			rd_word.raw[cop_pkg::TID_W-1:0] = cur_thread.tid;
		end
		cop_pkg::CPR_ADDR_NPC: begin
			rd_word.raw[cop_pkg::WORD_ADDR_W-1:0] = cur_thread.npc;
		end
		default: begin
		end
		endcase
	end

	assign cpr_rd_data = rd_word.raw;

endmodule

`default_nettype wire

//--- hw/cop_thread_sched.sv
// Purely combinational and acts only on the op in write-back, with no queuing of thread requests
`timescale 1ns/1ps
`default_nettype none

module cop_thread_sched (
	input  cop_pkg::thread_state_t [cop_pkg::PID_NUM-1:0] threads,
	input  wire logic [cop_pkg::PID_W-1:0]                cur_pid,
	input  cop_pkg::wb_cop_t                              wb,
	output cop_pkg::thread_cmd_t                          cmd
);

	logic                               same_en;
	logic [cop_pkg::PID_W-1:0]          same_pid;
	logic                               next_en;
	logic [cop_pkg::PID_W-1:0]          next_pid;
	logic                               blank_en;
	logic [cop_pkg::PID_W-1:0]          blank_pid;
	logic                               run_en;
	logic [cop_pkg::WORD_ADDR_W-1:0]    resume_pc;
	logic [cop_pkg::WORD_ADDR_W-1:0]    return_pc;

	function automatic logic eligible(input cop_pkg::thread_state_t t);
		return t.en & t.act & t.ne;
	endfunction

	// Highest enabled slot with a matching tid
	always_comb begin
		same_en  = 1'b0;
		same_pid = '0;
		for (int i = 0; i < cop_pkg::PID_NUM; i++) begin
			if (threads[i].en && threads[i].tid == wb.rd_data.raw[cop_pkg::TID_W-1:0]) begin
				same_en  = 1'b1;
				same_pid = i[cop_pkg::PID_W-1:0];
			end
		end
	end

	// Round robin from cur_pid+1, nearest candidate scanned last so it wins
	always_comb begin
		logic [cop_pkg::PID_W-1:0] idx;
		next_en  = 1'b0;
		next_pid = cur_pid;
		for (int k = cop_pkg::PID_NUM - 1; k > 0; k--) begin
			idx = cur_pid + k[cop_pkg::PID_W-1:0];
			if (eligible(threads[idx])) begin
				next_en  = 1'b1;
				next_pid = idx;
			end
		end
	end

	// Lowest free slot
	always_comb begin
		blank_en  = 1'b0;
		blank_pid = '0;
		for (int i = cop_pkg::PID_NUM - 1; i >= 0; i--) begin
			if (!threads[i].en) begin
				blank_en  = 1'b1;
				blank_pid = i[cop_pkg::PID_W-1:0];
			end
		end
	end

	assign run_en    = threads[cur_pid].en & threads[cur_pid].act;
	assign return_pc = wb.pc + 1'b1;
	// A delay slot restarts at its branch
	assign resume_pc = wb.bd ? wb.pc - 1'b1 : wb.pc;

	always_comb begin
		cmd          = '0;
		cmd.run_en   = run_en;
		cmd.next_en  = next_en;
		cmd.save_pid = cur_pid;
		case (wb.op)
		cop_pkg::MKTH: begin
			cmd.result_en = 1'b1;
			if (!same_en && blank_en) begin
				cmd.result   = 1'b1;
				cmd.make_en  = 1'b1;
				cmd.make_pid = blank_pid;
				cmd.make_tid = wb.rd_data.raw[cop_pkg::TID_W-1:0];
			end
		end
		cop_pkg::DELTH: begin
			cmd.result_en = 1'b1;
			if (same_en) begin
				cmd.result  = 1'b1;
				cmd.del_en  = 1'b1;
				cmd.del_pid = same_pid;
				// Deleting itself, so leave for the next thread or park at pid 0
				if (same_pid == cur_pid) begin
					cmd.all_flush   = 1'b1;
					cmd.switch_en   = 1'b1;
					cmd.pc_load_en  = 1'b1;
					cmd.new_pid     = next_en ? next_pid : '0;
					cmd.pc_load_val = next_en ? threads[next_pid].npc : '0;
				end
			end
		end
		cop_pkg::SWTH: begin
			cmd.result_en = 1'b1;
			if (same_en && same_pid != cur_pid) begin
				cmd.result      = 1'b1;
				cmd.all_flush   = 1'b1;
				cmd.switch_en   = 1'b1;
				cmd.new_pid     = same_pid;
				cmd.save_en     = 1'b1;
				cmd.save_npc    = return_pc;
				cmd.pc_load_en  = 1'b1;
				cmd.pc_load_val = threads[same_pid].npc;
			end
		end
		cop_pkg::NEXTTH: begin
			cmd.result_en = 1'b1;
			if (next_en) begin
				cmd.result      = 1'b1;
				cmd.all_flush   = 1'b1;
				cmd.switch_en   = 1'b1;
				cmd.new_pid     = next_pid;
				cmd.save_en     = 1'b1;
				cmd.save_npc    = return_pc;
				cmd.pc_load_en  = 1'b1;
				cmd.pc_load_val = threads[next_pid].npc;
			end
		end
		cop_pkg::SWITCH: begin
			cmd.all_flush  = 1'b1;
			cmd.pc_load_en = 1'b1;
			if (next_en) begin
				cmd.switch_en   = 1'b1;
				cmd.new_pid     = next_pid;
				cmd.save_en     = 1'b1;
				cmd.save_npc    = resume_pc;
				cmd.pc_load_val = threads[next_pid].npc;
			end else begin
				cmd.pc_load_val = resume_pc;
			end
		end
		default: begin
		end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/pu_cop.sv
// Thread ops act in the write-back cycle and expect wb.op to be NOP when no instruction retires
`timescale 1ns/1ps
`default_nettype none

module pu_cop (
	input  wire logic                                clk,
	input  wire logic                                rst_,
	input  cop_pkg::wb_cop_t                         wb,
	input  cop_pkg::stage_bits_t                     busy,
	input  wire logic                                id_hazard,
	input  wire logic                                branch_en,
	input  wire logic [cop_pkg::WORD_ADDR_W-1:0]     branch_pc,
	input  wire logic [cop_pkg::CPR_ADDR_W-1:0]      cpr_rd_addr,
	output logic [cop_pkg::WORD_W-1:0]               cpr_rd_data,
	output cop_pkg::stage_bits_t                     stall,
	output cop_pkg::stage_bits_t                     flush,
	output logic [cop_pkg::WORD_ADDR_W-1:0]          cop_np_pc,
	output logic [cop_pkg::WORD_ADDR_W-1:0]          cop_pr_pc,
	output logic [cop_pkg::PID_W-1:0]                pid,
	output logic [cop_pkg::TID_W-1:0]                tid,
	output logic                                     tmode,
	output logic                                     ne,
	output cop_pkg::cpr_ctrl_t                       ctrl,
	output logic [cop_pkg::CPR_ADDR_W-1:0]           cop_rd_addr,
	output logic                                     cop_rd_en,
	output logic [cop_pkg::WORD_W-1:0]               cop_rd_data
);

	cop_pkg::thread_state_t [cop_pkg::PID_NUM-1:0] threads;
	logic [cop_pkg::PID_W-1:0]                     cur_pid;
	cop_pkg::thread_cmd_t                          cmd;
	logic                                          pc_stall;

	cop_thread_regs u_regs (
		.clk         (clk),
		.rst_        (rst_),
		.cmd         (cmd),
		.wb          (wb),
		.cpr_rd_addr (cpr_rd_addr),
		.threads     (threads),
		.cur_pid     (cur_pid),
		.ctrl        (ctrl),
		.cpr_rd_data (cpr_rd_data)
	);

	cop_thread_sched u_sched (
		.threads (threads),
		.cur_pid (cur_pid),
		.wb      (wb),
		.cmd     (cmd)
	);

	cop_pipe_ctrl u_pipe (
		.busy      (busy),
		.id_hazard (id_hazard),
		.all_flush (cmd.all_flush),
		.stall     (stall),
		.flush     (flush),
		.pc_stall  (pc_stall)
	);

	cop_pc_gen u_pc (
		.clk       (clk),
		.rst_      (rst_),
		.cmd       (cmd),
		.branch_en (branch_en),
		.branch_pc (branch_pc),
		.pc_stall  (pc_stall),
		.cop_np_pc (cop_np_pc),
		.cop_pr_pc (cop_pr_pc)
	);

	// Current thread view for the pipeline
	assign pid   = cur_pid;
	assign tid   = threads[cur_pid].tid;
	assign tmode = threads[cur_pid].ku;
	assign ne    = cmd.next_en;

	// Thread ops return their 0/1 result in place of the GPR data
	assign cop_rd_addr = wb.rd_addr;
	assign cop_rd_en   = wb.rd_en;
	assign cop_rd_data = cmd.result_en ? {{(cop_pkg::WORD_W-1){1'b0}}, cmd.result}
		: wb.rd_data.raw;

endmodule

`default_nettype wire

//--- tests/cop_ref_model.svh
// Include inside the testbench module only; the model assumes four slots and tracks the DUT from reset release
`ifndef COP_REF_MODEL_SVH
`define COP_REF_MODEL_SVH

localparam cop_pkg::thread_state_t IDLE_SLOT = '{en: 1'b0, act: 1'b0, ne: 1'b0, ku: 1'b1,
	tid: 8'd0, npc: 30'd0};
localparam cop_pkg::thread_state_t BOOT_SLOT = '{en: 1'b1, act: 1'b1, ne: 1'b1, ku: 1'b1,
	tid: 8'd0, npc: 30'd0};

// Model copy of the thread table and registers
cop_pkg::thread_state_t m_thr [cop_pkg::PID_NUM];
logic [1:0]             m_pid;
logic [4:0]             m_ctrl;
logic [29:0]            m_pc;

// Expected decision for the op now in write-back
logic        d_flush_all;
logic        d_load;
logic        d_switch;
logic        d_save;
logic        d_res_en;
logic        d_res;
logic [29:0] d_load_pc;
logic [29:0] d_save_pc;
logic [1:0]  d_new_pid;
int          d_make;
int          d_del;

task automatic reset_model();
	m_thr[0] = BOOT_SLOT;
	for (int i = 1; i < cop_pkg::PID_NUM; i++) begin
		m_thr[i] = IDLE_SLOT;
	end
	m_pid = 2'd0;
	m_ctrl = 5'd0;
	m_pc = 30'd0;
endtask

// Highest enabled slot holding tid t, -1 if none
function automatic int same_slot(input logic [7:0] t);
	int hit;
	hit = -1;
	for (int i = 0; i < cop_pkg::PID_NUM; i++) begin
		if (m_thr[i].en && m_thr[i].tid == t) begin
			hit = i;
		end
	end
	return hit;
endfunction

// Round robin from the slot after the current one
function automatic int next_slot();
	int p;
	for (int k = 1; k < cop_pkg::PID_NUM; k++) begin
		p = (m_pid + k) % cop_pkg::PID_NUM;
		if (m_thr[p].en && m_thr[p].act && m_thr[p].ne) begin
			return p;
		end
	end
	return -1;
endfunction

function automatic int blank_slot();
	for (int i = 0; i < cop_pkg::PID_NUM; i++) begin
		if (!m_thr[i].en) begin
			return i;
		end
	end
	return -1;
endfunction

task automatic take_switch(input int target, input logic [29:0] save_pc);
	d_flush_all = 1'b1;
	d_load = 1'b1;
	d_switch = 1'b1;
	d_save = 1'b1;
	d_new_pid = target[1:0];
	d_save_pc = save_pc;
	d_load_pc = m_thr[target].npc;
endtask

task automatic decide_op(input cop_pkg::wb_cop_t w);
	int          s;
	int          n;
	int          b;
	logic [29:0] resume;
	s = same_slot(w.rd_data.raw[7:0]);
	n = next_slot();
	b = blank_slot();
	resume = w.bd ? w.pc - 30'd1 : w.pc;
	{d_flush_all, d_load, d_switch, d_save, d_res_en, d_res} = 6'd0;
	d_load_pc = 30'd0;
	d_save_pc = 30'd0;
	d_new_pid = 2'd0;
	d_make = -1;
	d_del = -1;
	case (w.op)
	cop_pkg::MKTH: begin
		d_res_en = 1'b1;
		if (s < 0 && b >= 0) begin
			d_res = 1'b1;
			d_make = b;
		end
	end
	cop_pkg::DELTH: begin
		d_res_en = 1'b1;
		if (s >= 0) begin
			d_res = 1'b1;
			d_del = s;
			if (s == int'(m_pid)) begin
				d_flush_all = 1'b1;
				d_load = 1'b1;
				d_switch = 1'b1;
				if (n >= 0) begin
					d_new_pid = n[1:0];
					d_load_pc = m_thr[n].npc;
				end
			end
		end
	end
	cop_pkg::SWTH: begin
		d_res_en = 1'b1;
		if (s >= 0 && s != int'(m_pid)) begin
			d_res = 1'b1;
			take_switch(s, w.pc + 30'd1);
		end
	end
	cop_pkg::NEXTTH: begin
		d_res_en = 1'b1;
		if (n >= 0) begin
			d_res = 1'b1;
			take_switch(n, w.pc + 30'd1);
		end
	end
	cop_pkg::SWITCH: begin
		d_flush_all = 1'b1;
		d_load = 1'b1;
		d_load_pc = resume;
		if (n >= 0) begin
			take_switch(n, resume);
		end
	end
	default: begin
	end
	endcase
endtask

task automatic commit_op(input cop_pkg::wb_cop_t w, input logic [29:0] np);
	if (w.op == cop_pkg::MT) begin
		case (w.rd_addr)
		cop_pkg::CPR_ADDR_PID: m_pid = w.rd_data.raw[1:0];
		cop_pkg::CPR_ADDR_CTRL: m_ctrl = w.rd_data.raw[4:0];
		cop_pkg::CPR_ADDR_STATUS: begin
			m_thr[m_pid].en = w.rd_data.raw[0];
			m_thr[m_pid].act = w.rd_data.raw[1];
			m_thr[m_pid].ne = w.rd_data.raw[2];
			m_thr[m_pid].ku = w.rd_data.raw[3];
		end
		cop_pkg::CPR_ADDR_TID: m_thr[m_pid].tid = w.rd_data.raw[7:0];
		cop_pkg::CPR_ADDR_NPC: m_thr[m_pid].npc = w.rd_data.raw[29:0];
		default: begin
		end
		endcase
	end
	if (d_make >= 0) begin
		m_thr[d_make].en = 1'b1;
		m_thr[d_make].act = 1'b1;
		m_thr[d_make].ne = 1'b1;
		m_thr[d_make].tid = w.rd_data.raw[7:0];
		m_thr[d_make].npc = w.cop_data[29:0];
	end
	if (d_del >= 0) begin
		m_thr[d_del] = IDLE_SLOT;
	end
	// Old thread keeps its resume point
	if (d_save) begin
		m_thr[m_pid].npc = d_save_pc;
	end
	if (d_switch) begin
		m_pid = d_new_pid;
	end
	m_pc = np;
endtask

// ia is the top bit, wb the bottom one
function automatic logic [4:0] stalls_for(input logic [4:0] b, input logic hz, input logic all);
	logic [4:0] s;
	for (int i = 0; i < 5; i++) begin
		s[i] = |(b & ~(5'b1 << i));
	end
	s[4] = s[4] | hz;
	return all ? 5'd0 : s;
endfunction

function automatic logic [4:0] flushes_for(input logic hz, input logic all);
	return all ? 5'b11111 : {1'b0, hz, 3'b000};
endfunction

function automatic logic [29:0] next_fetch_pc(input logic [4:0] b, input logic hz,
		input logic br, input logic [29:0] bpc);
	if (d_load) begin
		return d_load_pc;
	end
	if (!(m_thr[m_pid].en && m_thr[m_pid].act)) begin
		return 30'd0;
	end
	if ((|b) || hz) begin
		return m_pc;
	end
	return br ? bpc : m_pc + 30'd1;
endfunction

function automatic logic [31:0] cpr_value(input logic [4:0] a);
	case (a)
	cop_pkg::CPR_ADDR_PID: return {30'd0, m_pid};
	cop_pkg::CPR_ADDR_CTRL: return {27'd0, m_ctrl};
	cop_pkg::CPR_ADDR_STATUS: return {28'd0, m_thr[m_pid].ku, m_thr[m_pid].ne,
		m_thr[m_pid].act, m_thr[m_pid].en};
	cop_pkg::CPR_ADDR_TID: return {24'd0, m_thr[m_pid].tid};
	cop_pkg::CPR_ADDR_NPC: return {2'd0, m_thr[m_pid].npc};
	default: return 32'd0;
	endcase
endfunction

`endif

//--- tests/tb_pu_cop.sv
// Every cycle after reset all DUT outputs are compared with the model, wb.op is NOP between thread ops
`timescale 1ns/1ps
`default_nettype none

module tb_pu_cop;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	// Cycles spent by each test where one retire takes three
	localparam int RUN_CYCLES = 8 + 6 * 3 + 60 + 5 * 3 + 4 + 8 * 3 + 5 * 3;
	localparam int MAX_CYCLES = 2 * (RESET_CYCLES + RUN_CYCLES);

	logic                                clk = 1'b0;
	logic                                rst_;
	cop_pkg::wb_cop_t                    wb;
	cop_pkg::stage_bits_t                busy;
	logic                                id_hazard;
	logic                                branch_en;
	logic [cop_pkg::WORD_ADDR_W-1:0]     branch_pc;
	logic [cop_pkg::CPR_ADDR_W-1:0]      cpr_rd_addr;
	logic [cop_pkg::WORD_W-1:0]          cpr_rd_data;
	cop_pkg::stage_bits_t                stall;
	cop_pkg::stage_bits_t                flush;
	logic [cop_pkg::WORD_ADDR_W-1:0]     cop_np_pc;
	logic [cop_pkg::WORD_ADDR_W-1:0]     cop_pr_pc;
	logic [cop_pkg::PID_W-1:0]           pid;
	logic [cop_pkg::TID_W-1:0]           tid;
	logic                                tmode;
	logic                                ne;
	cop_pkg::cpr_ctrl_t                  ctrl;
	logic [cop_pkg::CPR_ADDR_W-1:0]      cop_rd_addr;
	logic                                cop_rd_en;
	logic [cop_pkg::WORD_W-1:0]          cop_rd_data;

	int          seed;
	int          errors = 0;
	int          test_base;
	int          tests_run = 0;
	int          cycles = 0;
	string       test_name = "reset";
	logic        pending = 1'b0;
	logic [29:0] np_seen;
	logic [31:0] r;

	`include "cop_ref_model.svh"

	pu_cop UUT (.*);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	// Model follows the edge, outputs are checked late in the cycle
	always @(posedge clk) begin
		if (!rst_) begin
			reset_model();
			pending = 1'b0;
		end else if (pending) begin
			commit_op(wb, np_seen);
		end
		#(PERIOD - 10);
		if (rst_) begin
			decide_op(wb);
			np_seen = next_fetch_pc(busy, id_hazard, branch_en, branch_pc);
			compare("stall", 32'(stalls_for(busy, id_hazard, d_flush_all)), 32'(stall));
			compare("flush", 32'(flushes_for(id_hazard, d_flush_all)), 32'(flush));
			compare("np_pc", 32'(np_seen), 32'(cop_np_pc));
			compare("pr_pc", 32'(m_pc), 32'(cop_pr_pc));
			compare("cpr_rd_data", cpr_value(cpr_rd_addr), cpr_rd_data);
			compare("cop_rd_data", d_res_en ? {31'd0, d_res} : wb.rd_data.raw, cop_rd_data);
			compare("cop_rd_addr", 32'(wb.rd_addr), 32'(cop_rd_addr));
			compare("cop_rd_en", 32'(wb.rd_en), 32'(cop_rd_en));
			compare("pid", 32'(m_pid), 32'(pid));
			compare("tid", 32'(m_thr[m_pid].tid), 32'(tid));
			compare("tmode", 32'(m_thr[m_pid].ku), 32'(tmode));
			compare("ne", 32'(next_slot() >= 0), 32'(ne));
			compare("ctrl", {27'd0, m_ctrl}, ctrl);
			pending = 1'b1;
		end
	end

	// CPR read address walks 0..7 so every register is read back
	task automatic next_cycle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			cpr_rd_addr = (cpr_rd_addr == 5'd7) ? 5'd0 : cpr_rd_addr + 5'd1;
		end
	endtask

	task automatic retire(input cop_pkg::cop_op_e op, input logic [4:0] addr,
			input logic [31:0] data, input logic [31:0] cdata, input logic [29:0] pc,
			input logic bd);
		wb.op = op;
		wb.rd_addr = addr;
		wb.rd_en = 1'b1;
		wb.rd_data.raw = data;
		wb.cop_data = cdata;
		wb.pc = pc;
		wb.bd = bd;
		next_cycle(1);
		wb.op = cop_pkg::NOP;
		wb.rd_en = 1'b0;
		next_cycle(2);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("Test %s done, %0d mismatches", test_name, errors - test_base);
	endtask

	initial begin
		seed = 32'h85b5;
		rst_ = 1'b0;
		wb = '0;
		busy = '0;
		id_hazard = 1'b0;
		branch_en = 1'b0;
		branch_pc = '0;
		cpr_rd_addr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_ = 1'b1;

		start_test("reset_state");
		next_cycle(8);
		end_test();

		start_test("ctrl_write");
		repeat (6) begin
			retire(cop_pkg::MT, cop_pkg::CPR_ADDR_CTRL, $random(seed), 32'd0, 30'd0, 1'b0);
		end
		end_test();

		start_test("stall_flush");
		repeat (60) begin
			r = $random(seed);
			busy = r[4:0] & r[9:5] & r[14:10];
			id_hazard = r[15] & r[16];
			branch_en = r[17];
			branch_pc = 30'($random(seed));
			wb.rd_data.raw = $random(seed);
			next_cycle(1);
		end
		busy = '0;
		id_hazard = 1'b0;
		branch_en = 1'b0;
		end_test();

		start_test("make_thread");
		retire(cop_pkg::MKTH, 5'd8, 32'h11, 32'h100, 30'h10, 1'b0);
		retire(cop_pkg::MKTH, 5'd8, 32'h11, 32'h180, 30'h14, 1'b0);
		retire(cop_pkg::MKTH, 5'd8, 32'h22, 32'h200, 30'h18, 1'b0);
		retire(cop_pkg::MT, cop_pkg::CPR_ADDR_PID, 32'd1, 32'd0, 30'h1c, 1'b0);
		// Hold pid 1 while the read walk passes STATUS, TID and NPC
		next_cycle(4);
		retire(cop_pkg::MT, cop_pkg::CPR_ADDR_PID, 32'd0, 32'd0, 30'h20, 1'b0);
		end_test();

		start_test("switch");
		// Stalls held across the first switch so the flush override shows
		busy = 5'b01001;
		id_hazard = 1'b1;
		retire(cop_pkg::NEXTTH, 5'd8, 32'd0, 32'd0, 30'h40, 1'b0);
		busy = '0;
		id_hazard = 1'b0;
		// Clear ne on slots 1 and 2 so slot 0 ends up alone
		retire(cop_pkg::MT, cop_pkg::CPR_ADDR_STATUS, 32'hb, 32'd0, 30'h101, 1'b0);
		retire(cop_pkg::SWTH, 5'd8, 32'h22, 32'd0, 30'h150, 1'b0);
		// Slot 2 also drops to user mode
		retire(cop_pkg::MT, cop_pkg::CPR_ADDR_STATUS, 32'h3, 32'd0, 30'h201, 1'b0);
		retire(cop_pkg::SWTH, 5'd8, 32'h00, 32'd0, 30'h250, 1'b0);
		retire(cop_pkg::NEXTTH, 5'd8, 32'd0, 32'd0, 30'h44, 1'b0);
		retire(cop_pkg::SWITCH, 5'd8, 32'd0, 32'd0, 30'h60, 1'b0);
		retire(cop_pkg::SWITCH, 5'd8, 32'd0, 32'd0, 30'h70, 1'b1);
		end_test();

		start_test("delete");
		retire(cop_pkg::DELTH, 5'd8, 32'h33, 32'd0, 30'h72, 1'b0);
		retire(cop_pkg::DELTH, 5'd8, 32'h22, 32'd0, 30'h74, 1'b0);
		retire(cop_pkg::SWTH, 5'd8, 32'h11, 32'd0, 30'h80, 1'b0);
		retire(cop_pkg::DELTH, 5'd8, 32'h11, 32'd0, 30'h153, 1'b0);
		retire(cop_pkg::DELTH, 5'd8, 32'h00, 32'd0, 30'h83, 1'b0);
		end_test();

		$display("Summary: %0d tests, %0d mismatches", tests_run, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
hw/cop_pkg.sv
hw/cop_thread_regs.sv
hw/cop_thread_sched.sv
hw/cop_pipe_ctrl.sv
hw/cop_pc_gen.sv
hw/pu_cop.sv
tests/tb_pu_cop.sv
